//--- src.f
hw/icache_ctrl_pkg.sv
hw/icache_ack_collector.sv
hw/icache_stat_sum.sv
hw/icache_ctrl_fsm.sv
hw/icache_ctrl_regs.sv
hw/icache_ctrl_top.sv
tb/icache_core_model.sv
tb/tb_icache_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_icache_ctrl -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- tb/tb_icache_ctrl.sv
// **************************************************************************
// Testbench for the cache control unit with four behavioral caches.
// Random register traffic is checked against a register and counter model;
// the first mismatch ends the run.
// **************************************************************************

`timescale 1ns/10ps

module tb_icache_ctrl;

    import icache_ctrl_pkg::*;

    localparam int unsigned NB_CORES = 4;
    localparam int unsigned N_ENABLE = 16;
    localparam int unsigned N_FLUSH  = 16;
    localparam int unsigned N_STAT   = 8;
    localparam int unsigned N_WILD   = 8;
    localparam int unsigned N_READ   = 80;
    localparam int unsigned N_OPS    = 6 + N_ENABLE + N_FLUSH + 2 * N_STAT + N_WILD + N_READ;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         req;
    logic [OFFS_W-1:0]            addr;
    logic                         wen;
    logic [DATA_W-1:0]            wdata;
    logic [ID_W-1:0]              id;
    logic                         gnt;
    logic                         r_valid;
    logic [ID_W-1:0]              r_id;
    logic [DATA_W-1:0]            r_rdata;
    logic [NB_CORES-1:0]          bypass_req;
    logic [NB_CORES-1:0]          bypass_ack;
    logic [NB_CORES-1:0]          flush_req;
    logic [NB_CORES-1:0]          flush_ack;
    logic [NB_CORES-1:0]          stat_clear;
    logic [NB_CORES-1:0]          stat_enable;
    logic [NB_CORES*DATA_W-1:0]   hit_cnt;
    logic [NB_CORES*DATA_W-1:0]   trans_cnt;
    logic [NB_CORES*DATA_W-1:0]   miss_cnt;
    logic                         cnt_we;
    logic [7:0]                   cnt_core;
    logic [DATA_W-1:0]            cnt_hit;
    logic [DATA_W-1:0]            cnt_trans;
    logic [DATA_W-1:0]            cnt_miss;
    logic [31:0]                  rnd_state;
    logic [31:0]                  delay_state;

    // Reference model state
    logic [DATA_W-1:0] enable_m;
    logic [DATA_W-1:0] flush_m;
    logic [DATA_W-1:0] clear_m;
    logic [DATA_W-1:0] stat_en_m;
    logic [DATA_W-1:0] hit_m   [NB_CORES];
    logic [DATA_W-1:0] trans_m [NB_CORES];
    logic [DATA_W-1:0] miss_m  [NB_CORES];

    icache_ctrl_top #(.NB_CORES(NB_CORES)) dut_i (
        .clk_i, .rst_ni,
        .req_i (req), .addr_i (addr), .wen_i (wen), .wdata_i (wdata), .id_i (id),
        .gnt_o (gnt), .r_valid_o (r_valid), .r_id_o (r_id), .r_rdata_o (r_rdata),
        .bypass_req_o (bypass_req), .bypass_ack_i (bypass_ack),
        .flush_req_o (flush_req), .flush_ack_i (flush_ack),
        .stat_clear_o (stat_clear), .stat_enable_o (stat_enable),
        .hit_cnt_i (hit_cnt), .trans_cnt_i (trans_cnt), .miss_cnt_i (miss_cnt)
    );

    icache_core_model #(.NB_CORES(NB_CORES)) caches_i (
        .clk_i, .rst_ni,
        .bypass_req_i (bypass_req), .flush_req_i (flush_req), .rand_i (delay_state),
        .cnt_we_i (cnt_we), .cnt_core_i (cnt_core),
        .cnt_hit_i (cnt_hit), .cnt_trans_i (cnt_trans), .cnt_miss_i (cnt_miss),
        .bypass_ack_o (bypass_ack), .flush_ack_o (flush_ack),
        .hit_cnt_o (hit_cnt), .trans_cnt_o (trans_cnt), .miss_cnt_o (miss_cnt)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    // Separate stream for the cache ack delays
    always @(posedge clk_i)
    begin
        #1;
        delay_state = xorshift(delay_state);
    end

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_with_fail($sformatf("[FAIL] %0t ns: %s is %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_id(input logic [ID_W-1:0] got, input logic [ID_W-1:0] exp,
                            input string what);
        if (got !== exp)
            stop_with_fail($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d",
                                     $time, what, got, exp));
    endtask

    task automatic check_mask(input logic [NB_CORES-1:0] got, input logic [NB_CORES-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_with_fail($sformatf("[FAIL] %0t ns: %s is %b, expected %b",
                                     $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_fail($sformatf("[FAIL] %0t ns: %s is %b, expected %b",
                                     $time, what, got, exp));
    endtask

    // Read map as seen by software
    function automatic logic [DATA_W-1:0] expected_read(input logic [OFFS_W-1:0] a);
        logic [DATA_W-1:0] sum_h;
        logic [DATA_W-1:0] sum_t;
        logic [DATA_W-1:0] sum_m;
        int                rel;
        int                core;
        sum_h = '0;
        sum_t = '0;
        sum_m = '0;
        for (int c = 0; c < NB_CORES; c++)
        begin
            sum_h = sum_h + hit_m[c];
            sum_t = sum_t + trans_m[c];
            sum_m = sum_m + miss_m[c];
        end
        case (a)
            OFFS_ENABLE:       return enable_m;
            OFFS_FLUSH:        return flush_m;
            OFFS_RESERVED:     return RESERVED_WORD;
            OFFS_STAT_CLEAR:   return clear_m;
            OFFS_STAT_ENABLE:  return stat_en_m;
            OFFS_GLOBAL_HIT:   return sum_h;
            OFFS_GLOBAL_TRANS: return sum_t;
            OFFS_GLOBAL_MISS:  return sum_m;
            default: ;
        endcase
        rel = int'(a) - int'(OFFS_CORE_BASE);
        if (rel < 0 || rel >= int'(MAX_CORES * CORE_STRIDE) || rel % 4 != 0)
            return PAD_WORD;
        core = rel / int'(CORE_STRIDE);
        if (core >= int'(NB_CORES))
            return PAD_WORD;   // Room in the map but no cache
        case ((rel % int'(CORE_STRIDE)) / 4)
            0:       return hit_m[core];
            1:       return trans_m[core];
            default: return miss_m[core];
        endcase
    endfunction

    // Holds the request until granted, returns just after the accepting edge
    task automatic issue(input logic [OFFS_W-1:0] a, input logic is_read,
                         input logic [DATA_W-1:0] data, output logic [ID_W-1:0] tid);
        logic granted;
        tid     = ID_W'(next_rand());
        req     = 1'b1;
        addr    = a;
        wen     = is_read;
        wdata   = data;
        id      = tid;
        granted = 1'b0;
        while (!granted)
        begin
            granted = gnt;
            @(posedge clk_i);
            #1;
        end
        req = 1'b0;
    endtask

    // Response is due two cycles after the first cycle with all acks matched
    task automatic wait_for_caches(input logic [NB_CORES-1:0] want, input logic is_flush,
                                   input logic [ID_W-1:0] tid);
        int i;
        int match_at;
        i        = 0;
        match_at = -1;
        forever
        begin
            if (match_at >= 0 && i == match_at + 2)
            begin
                check_flag(r_valid, 1'b1, "r_valid_o after acks matched");
                check_flag(gnt, 1'b1, "gnt_o in response cycle");
                check_id(r_id, tid, "r_id_o");
                check_data(r_rdata, '0, "write response data");
                return;
            end
            check_flag(r_valid, 1'b0, "r_valid_o before acks matched");
            check_flag(gnt, 1'b0, "gnt_o while waiting for caches");
            if (match_at < 0 && (is_flush ? flush_ack : bypass_ack) == want)
                match_at = i;
            @(posedge clk_i);
            #1;
            i++;
        end
    endtask

    task automatic write_reg(input logic [OFFS_W-1:0] a, input logic [DATA_W-1:0] data);
        logic [ID_W-1:0] tid;
        issue(a, 1'b0, data, tid);
        case (a)
            OFFS_ENABLE:
            begin
                enable_m = data;
                check_mask(bypass_req, ~data[NB_CORES-1:0], "bypass_req_o");
                wait_for_caches(~data[NB_CORES-1:0], 1'b0, tid);
            end
            OFFS_FLUSH:
            begin
                flush_m = data;
                check_mask(flush_req, data[NB_CORES-1:0], "flush_req_o");
                wait_for_caches(data[NB_CORES-1:0], 1'b1, tid);
            end
            default:
            begin
                if (a == OFFS_STAT_CLEAR)
                    clear_m = data;
                if (a == OFFS_STAT_ENABLE)
                    stat_en_m = data;
                check_flag(r_valid, 1'b1, "write response strobe");
                check_id(r_id, tid, "r_id_o");
                check_data(r_rdata, '0, "write response data");
                check_mask(stat_clear, (a == OFFS_STAT_CLEAR) ? data[NB_CORES-1:0] : '0,
                           "stat_clear_o in response cycle");
                check_mask(stat_enable, stat_en_m[NB_CORES-1:0], "stat_enable_o");
                @(posedge clk_i);
                #1;
                check_flag(r_valid, 1'b0, "r_valid_o one cycle later");
                check_mask(stat_clear, '0, "stat_clear_o after the pulse");
            end
        endcase
    endtask

    task automatic read_check(input logic [OFFS_W-1:0] a);
        logic [ID_W-1:0]   tid;
        logic [DATA_W-1:0] exp;
        exp = expected_read(a);
        issue(a, 1'b1, '0, tid);
        check_flag(r_valid, 1'b1, "read response strobe");
        check_id(r_id, tid, "r_id_o");
        check_data(r_rdata, exp, $sformatf("read data at offset %h", a));
    endtask

    task automatic load_counters(input int core);
        cnt_we    = 1'b1;
        cnt_core  = 8'(core);
        cnt_hit   = next_rand();
        cnt_trans = next_rand();
        cnt_miss  = next_rand();
        @(posedge clk_i);
        #1;
        cnt_we        = 1'b0;
        hit_m[core]   = cnt_hit;
        trans_m[core] = cnt_trans;
        miss_m[core]  = cnt_miss;
    endtask

    // Run limit scales with the number of bus operations
    initial
    begin
        repeat (N_OPS * 200) @(posedge clk_i);
        stop_with_fail("Timeout: no response arrived from the DUT in time");
    end

    initial
    begin
        logic [31:0] r;
        rst_ni      = 1'b0;
        req         = 1'b0;
        addr        = '0;
        wen         = 1'b0;
        wdata       = '0;
        id          = '0;
        cnt_we      = 1'b0;
        cnt_core    = '0;
        cnt_hit     = '0;
        cnt_trans   = '0;
        cnt_miss    = '0;
        rnd_state   = 32'h70e7;
        delay_state = 32'h70e7 ^ 32'h9e37_79b9;
        enable_m    = '0;
        flush_m     = '0;
        clear_m     = '0;
        stat_en_m   = '0;
        for (int c = 0; c < NB_CORES; c++)
        begin
            hit_m[c]   = '0;
            trans_m[c] = '0;
            miss_m[c]  = '0;
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        check_flag(gnt, 1'b1, "gnt_o after reset");
        check_flag(r_valid, 1'b0, "r_valid_o after reset");
        check_mask(bypass_req, '1, "bypass_req_o after reset");
        read_check(OFFS_ENABLE);
        read_check(OFFS_FLUSH);
        read_check(OFFS_STAT_CLEAR);
        read_check(OFFS_STAT_ENABLE);
        read_check(OFFS_RESERVED);
        read_check(OFFS_GLOBAL_HIT);

        for (int k = 0; k < int'(N_ENABLE); k++)
            write_reg(OFFS_ENABLE, next_rand());
        for (int k = 0; k < int'(N_FLUSH); k++)
            write_reg(OFFS_FLUSH, (k % 4 == 0) ? '0 : next_rand());   // Zero masks too
        for (int k = 0; k < int'(N_STAT); k++)
        begin
            write_reg(OFFS_STAT_CLEAR, next_rand());
            write_reg(OFFS_STAT_ENABLE, next_rand());
        end
        for (int k = 0; k < int'(N_WILD); k++)
        begin
            r = next_rand();
            write_reg((k == 0) ? OFFS_RESERVED : OFFS_GLOBAL_HIT + OFFS_W'(4 * (r % 8)), r);
        end
        for (int k = 0; k < int'(N_READ); k++)
        begin
            if (k % 5 == 0)
                load_counters(int'(next_rand() % NB_CORES));
            r = next_rand();
            read_check((r[1:0] == 2'd0) ? OFFS_W'(r >> 8) : OFFS_W'(4 * ((r >> 8) % 36)));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tb/icache_core_model.sv
// **************************************************************************
// Behavioral per-core caches for the control unit testbench.
// Acknowledges follow requests after a random delay taken from rand_i;
// counters are loaded one core at a time through cnt_we_i.
// **************************************************************************

`timescale 1ns/10ps

module icache_core_model #(
    parameter int unsigned NB_CORES = 4
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic [NB_CORES-1:0]                         bypass_req_i,
    input  logic [NB_CORES-1:0]                         flush_req_i,
    input  logic [31:0]                                 rand_i,
    input  logic                                        cnt_we_i,
    input  logic [7:0]                                  cnt_core_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          cnt_hit_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          cnt_trans_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          cnt_miss_i,
    output logic [NB_CORES-1:0]                         bypass_ack_o,
    output logic [NB_CORES-1:0]                         flush_ack_o,
    output logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] hit_cnt_o,
    output logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] trans_cnt_o,
    output logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] miss_cnt_o
);

    import icache_ctrl_pkg::*;

    logic [2:0] byp_wait   [NB_CORES];
    logic [2:0] flush_wait [NB_CORES];

    // Delay of 1 to 7 cycles, a different slice of rand_i per core
    function automatic logic [2:0] pick_delay(input int shift);
        return 3'(1 + (rand_i >> shift) % 7);
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            bypass_ack_o <= '1;   // Reset state is all cores in bypass
            flush_ack_o  <= '0;
            hit_cnt_o    <= '0;
            trans_cnt_o  <= '0;
            miss_cnt_o   <= '0;
            for (int c = 0; c < NB_CORES; c++)
            begin
                byp_wait[c]   <= '0;
                flush_wait[c] <= '0;
            end
        end
        else
        begin
            for (int c = 0; c < NB_CORES; c++)
            begin
                if (bypass_ack_o[c] == bypass_req_i[c])
                    byp_wait[c] <= '0;
                else if (byp_wait[c] == 0)
                    byp_wait[c] <= pick_delay(3 * c);
                else if (byp_wait[c] == 1)
                    bypass_ack_o[c] <= bypass_req_i[c];
                else
                    byp_wait[c] <= byp_wait[c] - 3'd1;
                if (flush_ack_o[c] == flush_req_i[c])
                    flush_wait[c] <= '0;
                else if (flush_wait[c] == 0)
                    flush_wait[c] <= pick_delay(3 * c + 1);
                else if (flush_wait[c] == 1)
                    flush_ack_o[c] <= flush_req_i[c];
                else
                    flush_wait[c] <= flush_wait[c] - 3'd1;
            end
            if (cnt_we_i)
            begin
                hit_cnt_o[cnt_core_i*DATA_W +: DATA_W]   <= cnt_hit_i;
                trans_cnt_o[cnt_core_i*DATA_W +: DATA_W] <= cnt_trans_i;
                miss_cnt_o[cnt_core_i*DATA_W +: DATA_W]  <= cnt_miss_i;
            end
        end
    end

endmodule

//--- hw/icache_ctrl_top.sv
// **************************************************************************
// Control unit for per-core instruction caches behind a peripheral port.
// Set NB_CORES to the number of caches; counters arrive flattened, core 0
// in the lowest word.
// **************************************************************************

`timescale 1ns/10ps

module icache_ctrl_top #(
    parameter int unsigned NB_CORES = 8
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     req_i,
    input  logic [icache_ctrl_pkg::OFFS_W-1:0]       addr_i,
    input  logic                                     wen_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]       wdata_i,
    input  logic [icache_ctrl_pkg::ID_W-1:0]         id_i,
    output logic                                     gnt_o,
    output logic                                     r_valid_o,
    output logic [icache_ctrl_pkg::ID_W-1:0]         r_id_o,
    output logic [icache_ctrl_pkg::DATA_W-1:0]       r_rdata_o,
    output logic [NB_CORES-1:0]                      bypass_req_o,
    input  logic [NB_CORES-1:0]                      bypass_ack_i,
    output logic [NB_CORES-1:0]                      flush_req_o,
    input  logic [NB_CORES-1:0]                      flush_ack_i,
    output logic [NB_CORES-1:0]                      stat_clear_o,
    output logic [NB_CORES-1:0]                      stat_enable_o,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] hit_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] trans_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] miss_cnt_i
);

    import icache_ctrl_pkg::*;

    logic              wr_en;
    logic              rd_en;
    logic              stat_clear_pulse;
    logic              bypass_listen;
    logic              bypass_clear;
    logic              bypass_done;
    logic              flush_listen;
    logic              flush_clear;
    logic              flush_done;
    logic [DATA_W-1:0] global_hit;
    logic [DATA_W-1:0] global_trans;
    logic [DATA_W-1:0] global_miss;

    icache_ctrl_fsm fsm_i (
        .clk_i, .rst_ni, .req_i, .wen_i, .addr_i, .id_i,
        .gnt_o, .r_valid_o, .r_id_o,
        .wr_en_o            (wr_en),
        .rd_en_o            (rd_en),
        .stat_clear_pulse_o (stat_clear_pulse),
        .bypass_listen_o    (bypass_listen),
        .bypass_clear_o     (bypass_clear),
        .bypass_done_i      (bypass_done),
        .flush_listen_o     (flush_listen),
        .flush_clear_o      (flush_clear),
        .flush_done_i       (flush_done)
    );

    icache_ctrl_regs #(.NB_CORES(NB_CORES)) regs_i (
        .clk_i, .rst_ni,
        .wr_en_i            (wr_en),
        .rd_en_i            (rd_en),
        .addr_i, .wdata_i,
        .stat_clear_pulse_i (stat_clear_pulse),
        .hit_cnt_i, .trans_cnt_i, .miss_cnt_i,
        .global_hit_i       (global_hit),
        .global_trans_i     (global_trans),
        .global_miss_i      (global_miss),
        .bypass_req_o, .flush_req_o, .stat_clear_o, .stat_enable_o, .r_rdata_o
    );

    icache_ack_collector #(.NB_CORES(NB_CORES)) bypass_col_i (
        .clk_i, .rst_ni,
        .listen_i (bypass_listen),
        .clear_i  (bypass_clear),
        .req_i    (bypass_req_o),
        .ack_i    (bypass_ack_i),
        .done_o   (bypass_done)
    );

    icache_ack_collector #(.NB_CORES(NB_CORES)) flush_col_i (
        .clk_i, .rst_ni,
        .listen_i (flush_listen),
        .clear_i  (flush_clear),
        .req_i    (flush_req_o),
        .ack_i    (flush_ack_i),
        .done_o   (flush_done)
    );

    icache_stat_sum #(.NB_CORES(NB_CORES)) sum_i (
        .hit_cnt_i, .trans_cnt_i, .miss_cnt_i,
        .global_hit_o   (global_hit),
        .global_trans_o (global_trans),
        .global_miss_o  (global_miss)
    );

endmodule

//--- hw/icache_ctrl_regs.sv
// **************************************************************************
// Control registers and read map of the cache control unit.
// Drives the per-core request lines and registers the read data on the
// accepting edge; writes answer with zero data.
// **************************************************************************

`timescale 1ns/10ps

module icache_ctrl_regs #(
    parameter int unsigned NB_CORES = 8
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        wr_en_i,
    input  logic                                        rd_en_i,
    input  logic [icache_ctrl_pkg::OFFS_W-1:0]          addr_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          wdata_i,
    input  logic                                        stat_clear_pulse_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] hit_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] trans_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] miss_cnt_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          global_hit_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          global_trans_i,
    input  logic [icache_ctrl_pkg::DATA_W-1:0]          global_miss_i,
    output logic [NB_CORES-1:0]                         bypass_req_o,
    output logic [NB_CORES-1:0]                         flush_req_o,
    output logic [NB_CORES-1:0]                         stat_clear_o,
    output logic [NB_CORES-1:0]                         stat_enable_o,
    output logic [icache_ctrl_pkg::DATA_W-1:0]          r_rdata_o
);

    import icache_ctrl_pkg::*;

    logic [DATA_W-1:0] enable_q;
    logic [DATA_W-1:0] flush_q;
    logic [DATA_W-1:0] clear_q;
    logic [DATA_W-1:0] stat_en_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] hit_w   [MAX_CORES];
    logic [DATA_W-1:0] trans_w [MAX_CORES];
    logic [DATA_W-1:0] miss_w  [MAX_CORES];

    // Absent cores read as padding
    for (genvar g = 0; g < MAX_CORES; g++)
    begin : g_core
        if (g < NB_CORES)
        begin : g_present
            assign hit_w[g]   = hit_cnt_i[g*DATA_W +: DATA_W];
            assign trans_w[g] = trans_cnt_i[g*DATA_W +: DATA_W];
            assign miss_w[g]  = miss_cnt_i[g*DATA_W +: DATA_W];
        end
        else
        begin : g_absent
            assign hit_w[g]   = PAD_WORD;
            assign trans_w[g] = PAD_WORD;
            assign miss_w[g]  = PAD_WORD;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q  <= '0;   // All cores start in bypass
            flush_q   <= '0;
            clear_q   <= '0;
            stat_en_q <= '0;
        end
        else if (wr_en_i)
        begin
            case (addr_i)
                OFFS_ENABLE:      enable_q  <= wdata_i;
                OFFS_FLUSH:       flush_q   <= wdata_i;
                OFFS_STAT_CLEAR:  clear_q   <= wdata_i;
                OFFS_STAT_ENABLE: stat_en_q <= wdata_i;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        rd_word = PAD_WORD;
        case (addr_i)
            OFFS_ENABLE:       rd_word = enable_q;
            OFFS_FLUSH:        rd_word = flush_q;
            OFFS_RESERVED:     rd_word = RESERVED_WORD;
            OFFS_STAT_CLEAR:   rd_word = clear_q;
            OFFS_STAT_ENABLE:  rd_word = stat_en_q;
            OFFS_GLOBAL_HIT:   rd_word = global_hit_i;
            OFFS_GLOBAL_TRANS: rd_word = global_trans_i;
            OFFS_GLOBAL_MISS:  rd_word = global_miss_i;
            default: ;
        endcase
        for (int c = 0; c < MAX_CORES; c++)
        begin
            if (addr_i == OFFS_W'(OFFS_CORE_BASE + c * CORE_STRIDE))
                rd_word = hit_w[c];
            if (addr_i == OFFS_W'(OFFS_CORE_BASE + c * CORE_STRIDE + 4))
                rd_word = trans_w[c];
            if (addr_i == OFFS_W'(OFFS_CORE_BASE + c * CORE_STRIDE + 8))
                rd_word = miss_w[c];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rd_en_i)
            rdata_q <= rd_word;
        else if (wr_en_i)
            rdata_q <= '0;
    end

    assign r_rdata_o     = rdata_q;
    assign bypass_req_o  = ~enable_q[NB_CORES-1:0];
    assign flush_req_o   = flush_q[NB_CORES-1:0];
    assign stat_enable_o = stat_en_q[NB_CORES-1:0];
    assign stat_clear_o  = stat_clear_pulse_i ? clear_q[NB_CORES-1:0] : '0;

    // Pulse cycle directly follows the stat-clear write
    a_clear_after_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        stat_clear_pulse_i |-> $past(wr_en_i && (addr_i == OFFS_STAT_CLEAR)));

endmodule

//--- hw/icache_ctrl_fsm.sv
// **************************************************************************
// Main state machine of the cache control unit.
// Grants the port, decodes writes, waits for cache acknowledges and
// raises the one-cycle response strobe.
// **************************************************************************

`timescale 1ns/10ps

module icache_ctrl_fsm (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               req_i,
    input  logic                               wen_i,
    input  logic [icache_ctrl_pkg::OFFS_W-1:0] addr_i,
    input  logic [icache_ctrl_pkg::ID_W-1:0]   id_i,
    output logic                               gnt_o,
    output logic                               r_valid_o,
    output logic [icache_ctrl_pkg::ID_W-1:0]   r_id_o,
    output logic                               wr_en_o,
    output logic                               rd_en_o,
    output logic                               stat_clear_pulse_o,
    output logic                               bypass_listen_o,
    output logic                               bypass_clear_o,
    input  logic                               bypass_done_i,
    output logic                               flush_listen_o,
    output logic                               flush_clear_o,
    input  logic                               flush_done_i
);

    import icache_ctrl_pkg::*;

    localparam logic [1:0] IDLE        = 2'd0;
    localparam logic [1:0] WAIT_BYPASS = 2'd1;
    localparam logic [1:0] WAIT_FLUSH  = 2'd2;
    localparam logic [1:0] CLEAR_STAT  = 2'd3;

    logic [1:0]      state_q;
    logic [1:0]      state_d;
    logic            accept;
    logic            resp_d;
    logic            r_valid_q;
    logic [ID_W-1:0] id_q;

    assign gnt_o   = (state_q == IDLE);
    assign accept  = req_i & gnt_o;
    assign rd_en_o = accept & wen_i;    // wen high means read
    assign wr_en_o = accept & ~wen_i;

    // Collectors are cleared on the accepting edge
    assign bypass_clear_o     = wr_en_o && (addr_i == OFFS_ENABLE);
    assign flush_clear_o      = wr_en_o && (addr_i == OFFS_FLUSH);
    assign bypass_listen_o    = (state_q == WAIT_BYPASS);
    assign flush_listen_o     = (state_q == WAIT_FLUSH);
    assign stat_clear_pulse_o = (state_q == CLEAR_STAT);

    always_comb
    begin
        state_d = state_q;
        resp_d  = 1'b0;
        case (state_q)
            IDLE:
            begin
                resp_d = accept;
                if (bypass_clear_o)
                begin
                    state_d = WAIT_BYPASS;
                    resp_d  = 1'b0;
                end
                else if (flush_clear_o)
                begin
                    state_d = WAIT_FLUSH;
                    resp_d  = 1'b0;
                end
                else if (wr_en_o && (addr_i == OFFS_STAT_CLEAR))
                begin
                    state_d = CLEAR_STAT;   // Response lands with the pulse
                end
            end
            WAIT_BYPASS:
            begin
                if (bypass_done_i)
                begin
                    state_d = IDLE;
                    resp_d  = 1'b1;
                end
            end
            WAIT_FLUSH:
            begin
                if (flush_done_i)
                begin
                    state_d = IDLE;
                    resp_d  = 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q   <= IDLE;
            r_valid_q <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            r_valid_q <= resp_d;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept)
            id_q <= id_i;
    end

    assign r_valid_o = r_valid_q;
    assign r_id_o    = id_q;

    // Grant comes back with a response, or right after the clear pulse
    a_gnt_returns_with_resp: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(gnt_o) |-> (r_valid_o || $past(stat_clear_pulse_o)));

    // A second strobe needs a fresh acceptance
    a_single_resp: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !accept |=> !r_valid_o);

endmodule

//--- hw/icache_stat_sum.sv
// **************************************************************************
// Adds the per-core hit, transaction and miss counters into global totals.
// Purely combinational; sums wrap at the data width.
// **************************************************************************

`timescale 1ns/10ps

module icache_stat_sum #(
    parameter int unsigned NB_CORES = 8
) (
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] hit_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] trans_cnt_i,
    input  logic [NB_CORES*icache_ctrl_pkg::DATA_W-1:0] miss_cnt_i,
    output logic [icache_ctrl_pkg::DATA_W-1:0]          global_hit_o,
    output logic [icache_ctrl_pkg::DATA_W-1:0]          global_trans_o,
    output logic [icache_ctrl_pkg::DATA_W-1:0]          global_miss_o
);

    import icache_ctrl_pkg::*;

    always_comb
    begin
        global_hit_o   = '0;
        global_trans_o = '0;
        global_miss_o  = '0;
        for (int c = 0; c < NB_CORES; c++)
        begin
            global_hit_o   = global_hit_o   + hit_cnt_i[c*DATA_W +: DATA_W];
            global_trans_o = global_trans_o + trans_cnt_i[c*DATA_W +: DATA_W];
            global_miss_o  = global_miss_o  + miss_cnt_i[c*DATA_W +: DATA_W];
        end
    end

endmodule

//--- hw/icache_ack_collector.sv
// **************************************************************************
// Sticky record of cache acknowledges that match the current request.
// Cleared when a request is issued; done_o rises once every core matched.
// **************************************************************************

`timescale 1ns/10ps

module icache_ack_collector #(
    parameter int unsigned NB_CORES = 8
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                listen_i,
    input  logic                clear_i,
    input  logic [NB_CORES-1:0] req_i,
    input  logic [NB_CORES-1:0] ack_i,
    output logic                done_o
);

    logic [NB_CORES-1:0] seen_q;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            seen_q <= '0;
        else if (clear_i)
            seen_q <= '0;
        else if (listen_i)
            seen_q <= seen_q | ~(ack_i ^ req_i);   // Stays set once matched
    end

    assign done_o = &seen_q;

    // FSM never clears a collector it is waiting on
    a_clear_not_listen: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(clear_i && listen_i));

endmodule

//--- hw/icache_ctrl_pkg.sv
// **************************************************************************
// Shared constants for the instruction cache control unit.
// Holds the bus widths, the register byte offsets and the read-map words.
// Modules import it inside their bodies and use scoped names in headers.
// **************************************************************************

package icache_ctrl_pkg;

    localparam int unsigned DATA_W    = 32;
    localparam int unsigned OFFS_W    = 8;
    localparam int unsigned ID_W      = 5;
    localparam int unsigned MAX_CORES = 8;   // Cores the read map has room for

    // Writable registers
    localparam logic [OFFS_W-1:0] OFFS_ENABLE      = 8'h00;
    localparam logic [OFFS_W-1:0] OFFS_FLUSH       = 8'h04;
    localparam logic [OFFS_W-1:0] OFFS_STAT_CLEAR  = 8'h0C;
    localparam logic [OFFS_W-1:0] OFFS_STAT_ENABLE = 8'h10;

    // Read-only words
    localparam logic [OFFS_W-1:0] OFFS_RESERVED     = 8'h08;
    localparam logic [OFFS_W-1:0] OFFS_GLOBAL_HIT   = 8'h14;
    localparam logic [OFFS_W-1:0] OFFS_GLOBAL_TRANS = 8'h18;
    localparam logic [OFFS_W-1:0] OFFS_GLOBAL_MISS  = 8'h1C;
    localparam logic [OFFS_W-1:0] OFFS_CORE_BASE    = 8'h24;

    // Per-core block is hit, trans, miss
    localparam int unsigned CORE_STRIDE = 12;

    localparam logic [DATA_W-1:0] RESERVED_WORD = 32'hBADD_A555;
    localparam logic [DATA_W-1:0] PAD_WORD      = 32'hDEAD_A555;

endpackage
